// File: axil_iob_pkg.sv
package axil_iob_pkg;

   // Bus widths shared by AXI-Lite and IOb sides
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // IOb request, an all-zero wstrb marks a read
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } iob_req_t;

   // IOb slave answer
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              rvalid;
      logic              ready;
   } iob_rsp_t;

   // Bridge FSM states
   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,
      ST_ACCESS = 2'd1,
      ST_WRESP  = 2'd2,
      ST_RRESP  = 2'd3
   } bridge_state_e;

   // AXI response codes in use
   typedef enum logic [1:0] {
      RESP_OKAY   = 2'd0,
      RESP_SLVERR = 2'd2
   } axil_resp_e;

endpackage

// File: iob_wait_timer.sv
module iob_wait_timer #(
   parameter int LIMIT = 4
) (
   input  logic clk,
   input  logic arst_n,
   input  logic run,
   output logic expired
);

   localparam int CNT_W = (LIMIT > 0) ? $clog2(LIMIT + 1) : 1;
   localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(LIMIT);

   logic [CNT_W-1:0] count;

   // Counts cycles of run, holds at the limit, drops back when run goes low
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else if (!run) begin
         count <= '0;
      end else if (count != CNT_MAX) begin
         count <= count + 1'b1;
      end
   end

   // High once LIMIT full cycles of run have passed
   assign expired = run && (count == CNT_MAX);

endmodule

// File: axil_req_regs.sv
module axil_req_regs
   import axil_iob_pkg::*;
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic              cap_wr,
   input  logic              cap_rd,
   input  logic [ADDR_W-1:0] awaddr,
   input  logic [ADDR_W-1:0] araddr,
   input  logic [DATA_W-1:0] wdata,
   input  logic [STRB_W-1:0] wstrb,
   output iob_req_t          req,
   input  logic              rsp_load,
   input  logic              rsp_err,
   input  iob_rsp_t          iob_rsp,
   output logic [DATA_W-1:0] rdata,
   output axil_resp_e        resp
);

   // Request held for the whole IOb access
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         req <= '0;
      end else if (cap_wr) begin
         req.addr  <= awaddr;
         req.wdata <= wdata;
         req.wstrb <= wstrb;
      end else if (cap_rd) begin
         // Zero strobes tell the slave this is a read
         req.addr  <= araddr;
         req.wdata <= '0;
         req.wstrb <= '0;
      end
   end

   // Response side, held until the master takes B or R
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rdata <= '0;
         resp  <= RESP_OKAY;
      end else if (rsp_load) begin
         if (rsp_err) begin
            rdata <= '0;
            resp  <= RESP_SLVERR;
         end else begin
            rdata <= iob_rsp.rvalid ? iob_rsp.rdata : '0;
            resp  <= RESP_OKAY;
         end
      end
   end

endmodule

// File: axil_bridge_fsm.sv
module axil_bridge_fsm
   import axil_iob_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   // AXI-Lite handshakes
   input  logic     awvalid,
   input  logic     wvalid,
   input  logic     arvalid,
   input  logic     bready,
   input  logic     rready,
   output logic     awready,
   output logic     wready,
   output logic     arready,
   output logic     bvalid,
   output logic     rvalid,
   // Request and response register control
   output logic     cap_wr,
   output logic     cap_rd,
   output logic     rsp_load,
   output logic     rsp_err,
   // IOb side
   output logic     iob_valid,
   input  iob_rsp_t iob_rsp,
   // Timeout timer
   output logic     tmo_run,
   input  logic     tmo_expired
);

   bridge_state_e state;
   bridge_state_e state_nxt;
   logic          wr_q;
   logic          iob_valid_q;
   logic          wr_accept;
   logic          rd_accept;
   logic          done;

   // A complete write wins over a read offered on the same cycle
   assign wr_accept = (state == ST_IDLE) && awvalid && wvalid;
   assign rd_accept = (state == ST_IDLE) && arvalid && !(awvalid && wvalid);

   // Access ends on the slave answer or when the timeout fires
   assign done = (state == ST_ACCESS) && (iob_rsp.ready || tmo_expired);

   assign awready = wr_accept;
   assign wready  = wr_accept;
   assign arready = rd_accept;
   assign cap_wr  = wr_accept;
   assign cap_rd  = rd_accept;

   assign rsp_load = done;
   assign rsp_err  = done && !iob_rsp.ready;

   assign bvalid = (state == ST_WRESP);
   assign rvalid = (state == ST_RRESP);

   assign iob_valid = iob_valid_q;
   assign tmo_run   = iob_valid_q;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (wr_accept || rd_accept) begin
               state_nxt = ST_ACCESS;
            end
         end
         ST_ACCESS: begin
            if (done) begin
               state_nxt = wr_q ? ST_WRESP : ST_RRESP;
            end
         end
         ST_WRESP: begin
            if (bready) begin
               state_nxt = ST_IDLE;
            end
         end
         ST_RRESP: begin
            if (rready) begin
               state_nxt = ST_IDLE;
            end
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state       <= ST_IDLE;
         wr_q        <= 1'b0;
         iob_valid_q <= 1'b0;
      end else begin
         state <= state_nxt;
         if (wr_accept) begin
            wr_q <= 1'b1;
         end else if (rd_accept) begin
            wr_q <= 1'b0;
         end
         // Valid follows the accept by one cycle and drops with the answer
         iob_valid_q <= (state == ST_ACCESS) && !done;
      end
   end

endmodule

// File: iob_regfile_slave.sv
module iob_regfile_slave
   import axil_iob_pkg::*;
#(
   parameter int N_REGS   = 8,
   parameter int WAIT_CYC = 2
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     valid,
   input  iob_req_t req,
   output iob_rsp_t rsp
);

   localparam int IDX_W = (N_REGS > 1) ? $clog2(N_REGS) : 1;

   logic [DATA_W-1:0] mem [N_REGS];
   logic [ADDR_W-3:0] word_idx;
   logic [IDX_W-1:0]  idx;
   logic              mapped;
   logic              is_read;
   logic              wait_done;
   logic              answer;

   // Word addressing, byte offset ignored
   assign word_idx = req.addr[ADDR_W-1:2];
   assign idx      = word_idx[IDX_W-1:0];
   assign mapped   = (word_idx < N_REGS);
   assign is_read  = (req.wstrb == '0);

   // Fixed latency, only runs for words that exist
   iob_wait_timer #(
      .LIMIT(WAIT_CYC)
   ) wait0 (
      .clk    (clk),
      .arst_n (arst_n),
      .run    (valid && mapped),
      .expired(wait_done)
   );

   // Unmapped words never get here, the bridge timeout ends them
   assign answer = valid && mapped && wait_done;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < N_REGS; i++) begin
            mem[i] <= '0;
         end
      end else if (answer && !is_read) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (req.wstrb[b]) begin
               mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
         end
      end
   end

   assign rsp.ready  = answer;
   assign rsp.rvalid = answer && is_read;
   assign rsp.rdata  = (answer && is_read) ? mem[idx] : '0;

endmodule

// File: axil_iob_sys.sv
module axil_iob_sys
   import axil_iob_pkg::*;
#(
   parameter int N_REGS      = 8,
   parameter int WAIT_CYC    = 2,
   parameter int TIMEOUT_CYC = 8
) (
   input  logic              clk,
   input  logic              arst_n,
   // Write address
   input  logic [ADDR_W-1:0] awaddr,
   input  logic              awvalid,
   output logic              awready,
   // Write data
   input  logic [DATA_W-1:0] wdata,
   input  logic [STRB_W-1:0] wstrb,
   input  logic              wvalid,
   output logic              wready,
   // Write response
   output logic [1:0]        bresp,
   output logic              bvalid,
   input  logic              bready,
   // Read address
   input  logic [ADDR_W-1:0] araddr,
   input  logic              arvalid,
   output logic              arready,
   // Read data
   output logic [DATA_W-1:0] rdata,
   output logic [1:0]        rresp,
   output logic              rvalid,
   input  logic              rready
);

   iob_req_t   req;
   iob_rsp_t   iob_rsp;
   axil_resp_e resp;
   logic       cap_wr;
   logic       cap_rd;
   logic       rsp_load;
   logic       rsp_err;
   logic       iob_valid;
   logic       tmo_run;
   logic       tmo_expired;

   // One response register feeds both channels
   assign bresp = resp;
   assign rresp = resp;

   axil_bridge_fsm fsm0 (
      .clk(clk), .arst_n(arst_n),
      .awvalid(awvalid), .wvalid(wvalid), .arvalid(arvalid),
      .bready(bready), .rready(rready),
      .awready(awready), .wready(wready), .arready(arready),
      .bvalid(bvalid), .rvalid(rvalid),
      .cap_wr(cap_wr), .cap_rd(cap_rd), .rsp_load(rsp_load), .rsp_err(rsp_err),
      .iob_valid(iob_valid), .iob_rsp(iob_rsp),
      .tmo_run(tmo_run), .tmo_expired(tmo_expired)
   );

   axil_req_regs regs0 (
      .clk(clk), .arst_n(arst_n),
      .cap_wr(cap_wr), .cap_rd(cap_rd),
      .awaddr(awaddr), .araddr(araddr), .wdata(wdata), .wstrb(wstrb),
      .req(req),
      .rsp_load(rsp_load), .rsp_err(rsp_err), .iob_rsp(iob_rsp),
      .rdata(rdata), .resp(resp)
   );

   // Transaction timeout
   iob_wait_timer #(
      .LIMIT(TIMEOUT_CYC)
   ) tmo0 (
      .clk(clk), .arst_n(arst_n), .run(tmo_run), .expired(tmo_expired)
   );

   iob_regfile_slave #(
      .N_REGS(N_REGS), .WAIT_CYC(WAIT_CYC)
   ) slave0 (
      .clk(clk), .arst_n(arst_n), .valid(iob_valid), .req(req), .rsp(iob_rsp)
   );

endmodule

// File: axil_iob_props.sv
module axil_iob_props
   import axil_iob_pkg::*;
(
   input logic              clk,
   input logic              arst_n,
   input logic              bvalid,
   input logic              bready,
   input logic              rvalid,
   input logic              rready,
   input logic              iob_valid,
   input axil_resp_e        resp,
   input logic [DATA_W-1:0] rdata
);

   // Read by the testbench at the end of the run
   int assert_fails = 0;

   a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
      bvalid && !bready |=> bvalid && $stable(resp))
      else begin
         assert_fails++;
         $error("bvalid or bresp changed before bready");
      end

   a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
      rvalid && !rready |=> rvalid && $stable(resp) && $stable(rdata))
      else begin
         assert_fails++;
         $error("rvalid, rresp or rdata changed before rready");
      end

   // No IOb access while a response waits on AXI
   a_iob_idle: assert property (@(posedge clk) disable iff (!arst_n)
      !(iob_valid && (bvalid || rvalid)))
      else begin
         assert_fails++;
         $error("iob_valid high together with a pending response");
      end

endmodule

bind axil_iob_sys axil_iob_props props0 (
   .clk(clk), .arst_n(arst_n),
   .bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready),
   .iob_valid(iob_valid), .resp(resp), .rdata(rdata)
);

// File: tb_axil_iob_sys.sv
module tb_axil_iob_sys;
   import axil_iob_pkg::*;

   localparam int N_REGS      = 8;
   localparam int WAIT_CYC    = 2;
   localparam int TIMEOUT_CYC = 8;
   localparam int RESET_CYC   = 16;
   localparam int N_VEC       = 18;
   localparam int N_TXN       = N_VEC + N_REGS + 2;
   localparam int MAX_CYC     = N_TXN * (TIMEOUT_CYC + 20) + RESET_CYC;

   typedef struct packed {
      logic              wr;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
      axil_resp_e        resp;
   } vec_t;

   logic              clk;
   logic              arst_n;
   logic [ADDR_W-1:0] awaddr;
   logic              awvalid;
   logic              awready;
   logic [DATA_W-1:0] wdata;
   logic [STRB_W-1:0] wstrb;
   logic              wvalid;
   logic              wready;
   logic [1:0]        bresp;
   logic              bvalid;
   logic              bready;
   logic [ADDR_W-1:0] araddr;
   logic              arvalid;
   logic              arready;
   logic [DATA_W-1:0] rdata;
   logic [1:0]        rresp;
   logic              rvalid;
   logic              rready;

   logic [DATA_W-1:0] shadow [N_REGS];
   int                errors = 0;
   int                cycles = 0;
   integer            seed = 14244;

   // op, addr, wdata, wstrb, expected response
   vec_t vecs [N_VEC] = '{
      '{1'b1, 16'h0000, 32'hDEAD_BEEF, 4'hF, RESP_OKAY},
      '{1'b0, 16'h0000, 32'h0000_0000, 4'h0, RESP_OKAY},
      '{1'b1, 16'h0004, 32'h1122_3344, 4'hF, RESP_OKAY},
      '{1'b1, 16'h0004, 32'hAABB_CCDD, 4'h5, RESP_OKAY},
      '{1'b0, 16'h0004, 32'h0000_0000, 4'h0, RESP_OKAY},
      '{1'b1, 16'h0008, 32'hCAFE_F00D, 4'hF, RESP_OKAY},
      '{1'b1, 16'h000B, 32'h7700_0000, 4'h8, RESP_OKAY},
      '{1'b1, 16'h0008, 32'h0000_0099, 4'h1, RESP_OKAY},
      '{1'b0, 16'h0008, 32'h0000_0000, 4'h0, RESP_OKAY},
      '{1'b1, 16'h001C, 32'h1234_5678, 4'h6, RESP_OKAY},
      '{1'b0, 16'h001C, 32'h0000_0000, 4'h0, RESP_OKAY},
      '{1'b1, 16'h0020, 32'hFFFF_FFFF, 4'hF, RESP_SLVERR},
      '{1'b0, 16'h0020, 32'h0000_0000, 4'h0, RESP_SLVERR},
      '{1'b1, 16'h0100, 32'h0BAD_F00D, 4'h3, RESP_SLVERR},
      '{1'b0, 16'h8000, 32'h0000_0000, 4'h0, RESP_SLVERR},
      '{1'b0, 16'h0000, 32'h0000_0000, 4'h0, RESP_OKAY},
      '{1'b0, 16'h0004, 32'h0000_0000, 4'h0, RESP_OKAY},
      '{1'b0, 16'h0018, 32'h0000_0000, 4'h0, RESP_OKAY}
   };

   axil_iob_sys #(
      .N_REGS(N_REGS), .WAIT_CYC(WAIT_CYC), .TIMEOUT_CYC(TIMEOUT_CYC)
   ) dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYC) begin
         $display("Run stopped, no end of test after %0d cycles", cycles);
         $display("Result: FAILED");
         $finish;
      end
   end

   task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
      if (got !== exp) begin
         errors++;
         $display("ERR %0t %s got %0d exp %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
      end
   endtask

   task automatic check_cycles(input string name, input int got, input int exp);
      if (got != exp) begin
         errors++;
         $display("ERR %0t %s got %0d exp %0d", $time, name, got, exp);
      end
   endtask

   task automatic protocol_error(input string what);
      errors++;
      $display("Protocol error at %0t: %s", $time, what);
   endtask

   // Entered 5 units after the accept edge, returns 5 units after the transfer
   task automatic collect_response(input bit wr, input int hold, output axil_resp_e resp,
                                   output logic [DATA_W-1:0] data, output int lat);
      lat = 0;
      @(negedge clk);
      while (!(wr ? bvalid : rvalid)) begin
         if (awready || arready)
            protocol_error("request accepted while an access is in flight");
         @(negedge clk);
         lat++;
      end
      resp = axil_resp_e'(wr ? bresp : rresp);
      data = rdata;
      // Back-pressure, response must hold and nothing new may enter
      repeat (hold) begin
         @(negedge clk);
         if (!(wr ? bvalid : rvalid))
            protocol_error("response valid dropped before ready");
         if (awready || arready)
            protocol_error("request accepted while a response is pending");
         check_resp(wr ? "held bresp" : "held rresp", axil_resp_e'(wr ? bresp : rresp), resp);
         check_data("held rdata", rdata, data);
      end
      @(posedge clk);
      #5;
      bready = wr;
      rready = !wr;
      @(posedge clk);
      #5;
      bready = 1'b0;
      rready = 1'b0;
   endtask

   task automatic run_txn(input vec_t v, output axil_resp_e resp,
                          output logic [DATA_W-1:0] data, output int lat);
      int hold;
      hold = $unsigned($random(seed)) % 6;
      @(posedge clk);
      #5;
      if (v.wr) begin
         awaddr  = v.addr;
         wdata   = v.wdata;
         wstrb   = v.wstrb;
         awvalid = 1'b1;
         wvalid  = 1'b1;
      end else begin
         araddr  = v.addr;
         arvalid = 1'b1;
      end
      @(negedge clk);
      while (!(v.wr ? (awready && wready) : arready)) @(negedge clk);
      @(posedge clk);
      #5;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      arvalid = 1'b0;
      collect_response(v.wr, hold, resp, data, lat);
   endtask

   task automatic apply_vec(input vec_t v);
      axil_resp_e        resp;
      logic [DATA_W-1:0] data;
      int                lat;
      int                widx;
      bit                mapped;
      mapped = (v.addr[ADDR_W-1:2] < N_REGS);
      widx   = int'(v.addr[ADDR_W-1:2]);
      run_txn(v, resp, data, lat);
      check_resp(v.wr ? "bresp" : "rresp", resp, v.resp);
      check_cycles("response latency", lat, mapped ? WAIT_CYC + 2 : TIMEOUT_CYC + 2);
      if (v.wr && mapped) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (v.wstrb[b])
               shadow[widx][8*b +: 8] = v.wdata[8*b +: 8];
         end
      end
      if (!v.wr)
         check_data("rdata", data, mapped ? shadow[widx] : '0);
   endtask

   // Write and read offered together, read stays pending through B back-pressure
   task automatic write_read_race(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      axil_resp_e        resp;
      logic [DATA_W-1:0] rd;
      int                lat;
      @(posedge clk);
      #5;
      awaddr  = addr;
      wdata   = data;
      wstrb   = '1;
      araddr  = addr;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      arvalid = 1'b1;
      @(negedge clk);
      if (!(awready && wready) || arready)
         protocol_error("write did not win over a simultaneous read");
      @(posedge clk);
      #5;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      shadow[addr[ADDR_W-1:2]] = data;
      collect_response(1'b1, 4, resp, rd, lat);
      check_resp("bresp", resp, RESP_OKAY);
      @(negedge clk);
      while (!arready) @(negedge clk);
      @(posedge clk);
      #5;
      arvalid = 1'b0;
      collect_response(1'b0, 2, resp, rd, lat);
      check_resp("rresp", resp, RESP_OKAY);
      check_data("rdata", rd, shadow[addr[ADDR_W-1:2]]);
   endtask

   initial begin
      vec_t v;
      arst_n  = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      for (int i = 0; i < N_REGS; i++)
         shadow[i] = '0;
      repeat (RESET_CYC) @(posedge clk);
      #5;
      arst_n = 1'b1;
      @(negedge clk);
      if (bvalid || rvalid || awready || wready || arready)
         protocol_error("handshake output high after reset");
      // Every register starts at zero
      for (int i = 0; i < N_REGS; i++) begin
         v = '0;
         v.addr = ADDR_W'(4 * i);
         apply_vec(v);
      end
      for (int i = 0; i < N_VEC; i++)
         apply_vec(vecs[i]);
      write_read_race(16'h0010, 32'h5A5A_0FF0);
      $display("Done: %0d check errors, %0d assertion failures",
               errors, dut0.props0.assert_fails);
      if (errors == 0 && dut0.props0.assert_fails == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// File: axil_iob_sys.f
axil_iob_pkg.sv
iob_wait_timer.sv
axil_req_regs.sv
axil_bridge_fsm.sv
iob_regfile_slave.sv
axil_iob_sys.sv
axil_iob_props.sv
tb_axil_iob_sys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the AXI-Lite to IOb testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_axil_iob_sys -f axil_iob_sys.f -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
   exit 0
fi
echo "Pass line not found in $LOG"
exit 1
